// File: build.f
+incdir+common
common/fifo_cfg_pkg.sv
common/fifo_io_pkg.sv
source/req_decode.sv
channel/channel_ctrl.sv
source/read_arbiter.sv
source/sram_sp.sv
source/fifo_mc_top.sv
tb/tb_fifo_mc.sv

// File: channel/channel_ctrl.sv
// Control for one logical FIFO channel inside the shared SRAM
// Holds the credit bank, read/write offsets and the data count.
// Offsets wrap at the configured size and are added to the base address.
// One instance per channel, driven by one-hot strobes from the top level

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module channel_ctrl
   import fifo_cfg_pkg::*;
   import fifo_io_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,      // Async, active low
   input  ch_cfg_t  cfg,        // Base and size of the region
   input  logic     push,       // Write offered to this channel
   input  logic     rqst,       // Read request, adds a credit
   input  logic     pop,        // Read granted by the arbiter
   output logic     rd_want,    // Credit pending and data stored
   output logic     push_ok,    // Write accepted
   output ch_addr_t addr,       // Physical write and read address
   output ch_sts_t  sts,
   output ch_err_t  err,
   output logic     rqst_rdy_n  // Credit bank full, hold requests
);

   localparam logic [`FIFO_CRD_W-1:0] CRD_MAX = `FIFO_CRD_N;

   logic [`FIFO_ADD_W-1:0] wr_off;  // Offset in the region
   logic [`FIFO_ADD_W-1:0] rd_off;
   logic [`FIFO_CNT_W-1:0] count;   // Stored words
   logic [`FIFO_CRD_W-1:0] crd_cnt; // Pending credits
   logic                   full;
   logic                   empty;
   logic                   crd_full;
   logic                   crd_empty;
   logic                   rqst_ok;
   ch_err_t                err_q;

   // Next offset, back to zero at the last word of the region
   function automatic logic [`FIFO_ADD_W-1:0] nxt_off(
      input logic [`FIFO_ADD_W-1:0] off,
      input logic [`FIFO_CNT_W-1:0] size
   );
      return ({1'b0, off} == size - 1'b1) ? '0 : off + 1'b1;
   endfunction

   assign full      = (count == cfg.size);
   assign empty     = (count == '0);
   assign crd_full  = (crd_cnt == CRD_MAX);
   assign crd_empty = (crd_cnt == '0);

   assign push_ok = push & ~full;      // Dropped when full
   assign rqst_ok = rqst & ~crd_full;  // Dropped when bank is full
   assign rd_want = ~crd_empty & ~empty;

   // Physical addresses, sums wrap inside the SRAM
   assign addr.wr_add = cfg.base + wr_off;
   assign addr.rd_add = cfg.base + rd_off;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_off  <= '0;
         rd_off  <= '0;
         count   <= '0;
         crd_cnt <= '0;
         err_q   <= '0;
      end else begin
         if (push_ok) wr_off <= nxt_off(wr_off, cfg.size);
         if (pop)     rd_off <= nxt_off(rd_off, cfg.size);

         // Push and pop never meet here, writes block grants
         case ({push_ok, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // A grant spends one credit
         case ({rqst_ok, pop})
            2'b10:   crd_cnt <= crd_cnt + 1'b1;
            2'b01:   crd_cnt <= crd_cnt - 1'b1;
            default: crd_cnt <= crd_cnt;
         endcase

         err_q.dat_ovfl  <= push & full;     // Pulse on the dropped write
         err_q.rqst_ovfl <= rqst & crd_full; // Pulse on the dropped request
      end
   end

   assign err = err_q;

   assign sts.count     = count;
   assign sts.full      = full;
   assign sts.empty     = empty;
   assign sts.crd_count = crd_cnt;
   assign sts.crd_full  = crd_full;
   assign sts.crd_empty = crd_empty;

   assign rqst_rdy_n = crd_full;

endmodule

// File: common/fifo_cfg_pkg.sv
// Per-channel configuration, status and error types
// Shared by the channel controllers and the top level

`include "fifo_mc_settings.svh"

package fifo_cfg_pkg;

   // Region of the SRAM owned by one channel
   typedef struct packed {
      logic [`FIFO_ADD_W-1:0] base; // First physical address
      logic [`FIFO_CNT_W-1:0] size; // Depth in words, wraps here
   } ch_cfg_t;

   // Fill and credit status of one channel
   typedef struct packed {
      logic [`FIFO_CNT_W-1:0] count;     // Words stored
      logic                   full;      // count reached size
      logic                   empty;     // No words stored
      logic [`FIFO_CRD_W-1:0] crd_count; // Pending read credits
      logic                   crd_full;  // Credit bank at depth
      logic                   crd_empty; // No credits pending
   } ch_sts_t;

   // One-cycle error pulses
   typedef struct packed {
      logic dat_ovfl;  // Write to a full channel, word dropped
      logic rqst_ovfl; // Request with credits full, request dropped
   } ch_err_t;

endpackage

// File: common/fifo_io_pkg.sv
// Data-path types of the multi-channel FIFO
// User side words, read requests, per-channel addresses and the SRAM port

`include "fifo_mc_settings.svh"

package fifo_io_pkg;

   // Tagged data word, used on the write input and the read output
   typedef struct packed {
      logic                   vld; // Word is valid this cycle
      logic [`FIFO_CH_W-1:0]  ch;  // Channel number
      logic [`FIFO_DAT_W-1:0] dat; // Payload
   } usr_word_t;

   // One read request per valid cycle
   typedef struct packed {
      logic                  vld;
      logic [`FIFO_CH_W-1:0] ch;
   } rd_req_t;

   // Physical addresses a channel would use next
   typedef struct packed {
      logic [`FIFO_ADD_W-1:0] wr_add; // Where the next write lands
      logic [`FIFO_ADD_W-1:0] rd_add; // Oldest stored word
   } ch_addr_t;

   // Single-port SRAM access
   typedef struct packed {
      logic                   cs;  // Chip select
      logic                   wen; // Write when set, else read
      logic [`FIFO_ADD_W-1:0] add;
      logic [`FIFO_DAT_W-1:0] dat; // Write data
   } mem_req_t;

endpackage

// File: common/fifo_mc_settings.svh
// Global sizing for the multi-channel FIFO controller
// Include this wherever a width or a count is needed; the packages build their types on it

`ifndef FIFO_MC_SETTINGS_SVH
`define FIFO_MC_SETTINGS_SVH

// Base sizes
`define FIFO_CH_N   4 // Number of logical channels
`define FIFO_ADD_W  4 // SRAM address width [bits]
`define FIFO_DAT_W  8 // Data word width [bits]
`define FIFO_CRD_N  4 // Read credits a channel can hold

// Derived widths
`define FIFO_CH_W   $clog2(`FIFO_CH_N)       // Channel index
`define FIFO_CNT_W  (`FIFO_ADD_W + 1)        // Data count, holds a full SRAM
`define FIFO_CRD_W  $clog2(`FIFO_CRD_N + 1)  // Credit count, holds CRD_N itself

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# The exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module tb_fifo_mc -f build.f \
   && ./obj_dir/Vtb_fifo_mc | tee /dev/stderr | grep -qx "TEST OK" \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

// File: source/fifo_mc_top.sv
// Multi-channel FIFO controller, several logical FIFOs in one SP-SRAM
// Writes arrive on usr_in and always win the SRAM; read requests on rd_in
// become credits. Granted reads leave on usr_out one cycle after the grant.
// Status, errors and request flow control are reported per channel

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module fifo_mc_top
   import fifo_cfg_pkg::*;
   import fifo_io_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,         // Async, active low
   input  ch_cfg_t   [`FIFO_CH_N-1:0]     cfg,           // Region per channel
   input  usr_word_t                      usr_in,        // Write path
   input  rd_req_t                        rd_in,         // Read requests
   output usr_word_t                      usr_out,       // Read data, tagged
   output logic      [`FIFO_CH_N-1:0]     fc_rqst_rdy_n, // Not ready for requests
   output ch_sts_t   [`FIFO_CH_N-1:0]     sts,
   output ch_err_t   [`FIFO_CH_N-1:0]     err
);

   logic     [`FIFO_CH_N-1:0]  push_oh;
   logic     [`FIFO_CH_N-1:0]  rqst_oh; // Adds a credit
   logic     [`FIFO_CH_N-1:0]  pop_oh;  // Spends a credit and a word
   logic     [`FIFO_CH_N-1:0]  rd_want;
   logic     [`FIFO_CH_N-1:0]  push_ok;
   ch_addr_t [`FIFO_CH_N-1:0]  addr;
   mem_req_t                   mem;
   logic     [`FIFO_DAT_W-1:0] rd_dat;

   req_decode i_req_decode (
      .usr_in  (usr_in),
      .rd_in   (rd_in),
      .push_oh (push_oh),
      .rqst_oh (rqst_oh)
   );

   // One controller per channel
   for (genvar ch = 0; ch < `FIFO_CH_N; ch++) begin : gen_ch
      channel_ctrl i_channel_ctrl (
         .clk        (clk),
         .rst_n      (rst_n),
         .cfg        (cfg[ch]),
         .push       (push_oh[ch]),
         .rqst       (rqst_oh[ch]),
         .pop        (pop_oh[ch]),
         .rd_want    (rd_want[ch]),
         .push_ok    (push_ok[ch]),
         .addr       (addr[ch]),
         .sts        (sts[ch]),
         .err        (err[ch]),
         .rqst_rdy_n (fc_rqst_rdy_n[ch])
      );
   end

   read_arbiter i_read_arbiter (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_want (rd_want),
      .push_oh (push_oh),
      .push_ok (push_ok),
      .addr    (addr),
      .wr_dat  (usr_in.dat), // Write payload goes straight to the SRAM
      .pop_oh  (pop_oh),
      .mem     (mem),
      .rd_dat  (rd_dat),
      .usr_out (usr_out)
   );

   sram_sp i_sram_sp (
      .clk    (clk),
      .mem    (mem),
      .rd_dat (rd_dat)
   );

endmodule

// File: source/read_arbiter.sv
// Strict-priority read arbiter and SRAM port mux
// Writes own the SRAM in their cycle; otherwise the lowest channel
// that wants a read is granted. Read data leaves one cycle later, tagged

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module read_arbiter
   import fifo_io_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic      [`FIFO_CH_N-1:0]       rd_want, // Credit and data present
   input  logic      [`FIFO_CH_N-1:0]       push_oh, // Write offered, one-hot
   input  logic      [`FIFO_CH_N-1:0]       push_ok, // Write accepted
   input  ch_addr_t  [`FIFO_CH_N-1:0]       addr,
   input  logic      [`FIFO_DAT_W-1:0]      wr_dat,
   output logic      [`FIFO_CH_N-1:0]       pop_oh,  // Grant, one-hot
   output mem_req_t                         mem,
   input  logic      [`FIFO_DAT_W-1:0]      rd_dat,  // SRAM read data, registered
   output usr_word_t                        usr_out
);

   logic [`FIFO_CH_N-1:0] rd_req;  // Read requests that may compete
   logic                  wr_any;  // Write offered this cycle
   logic                  wr_en;   // Write actually stored
   logic                  gnt_vld;
   logic [`FIFO_CH_W-1:0] wr_ch;
   logic [`FIFO_CH_W-1:0] gnt_ch;
   logic                  out_vld;
   logic [`FIFO_CH_W-1:0] out_ch;

   // One-hot to index
   function automatic logic [`FIFO_CH_W-1:0] oh2idx(input logic [`FIFO_CH_N-1:0] oh);
      logic [`FIFO_CH_W-1:0] idx;
      idx = '0;
      for (int i = 0; i < `FIFO_CH_N; i++) begin
         if (oh[i]) idx = idx | i[`FIFO_CH_W-1:0];
      end
      return idx;
   endfunction

   assign wr_any = |push_oh;
   assign wr_en  = |(push_oh & push_ok); // Dropped write leaves the SRAM idle
   assign rd_req = rd_want & {`FIFO_CH_N{~wr_any}};

   // Lowest set bit wins
   assign pop_oh  = rd_req & (~rd_req + 1'b1);
   assign gnt_vld = |pop_oh;
   assign wr_ch   = oh2idx(push_oh);
   assign gnt_ch  = oh2idx(pop_oh);

   assign mem.cs  = wr_en | gnt_vld;
   assign mem.wen = wr_en;
   assign mem.add = wr_any ? addr[wr_ch].wr_add : addr[gnt_ch].rd_add;
   assign mem.dat = wr_dat;

   // Tag follows the SRAM read by one cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_vld <= 1'b0;
         out_ch  <= '0;
      end else begin
         out_vld <= gnt_vld;
         out_ch  <= gnt_ch;
      end
   end

   assign usr_out.vld = out_vld;
   assign usr_out.ch  = out_ch;
   assign usr_out.dat = rd_dat;

endmodule

// File: source/req_decode.sv
// Turns the encoded channel numbers of writes and read requests into
// one-hot strobes, one bit per channel. Purely combinational

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module req_decode
   import fifo_io_pkg::*;
(
   input  usr_word_t              usr_in,  // Write strobe with channel number
   input  rd_req_t                rd_in,   // Read request with channel number
   output logic [`FIFO_CH_N-1:0]  push_oh, // Write, one bit per channel
   output logic [`FIFO_CH_N-1:0]  rqst_oh  // Read request, one bit per channel
);

   // Binary to one-hot, all zero unless enabled
   function automatic logic [`FIFO_CH_N-1:0] dec_oh(
      input logic [`FIFO_CH_W-1:0] ch,
      input logic                  en
   );
      logic [`FIFO_CH_N-1:0] oh;
      oh     = '0;
      oh[ch] = en;
      return oh;
   endfunction

   assign push_oh = dec_oh(usr_in.ch, usr_in.vld); // Writes
   assign rqst_oh = dec_oh(rd_in.ch, rd_in.vld);   // Credits in

endmodule

// File: source/sram_sp.sv
// Single-port synchronous SRAM holding all channel regions
// Writes land at the clock edge, reads return one cycle after the access

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module sram_sp
   import fifo_io_pkg::*;
(
   input  logic                   clk,
   input  mem_req_t               mem,    // Chip select, write enable, address, data
   output logic [`FIFO_DAT_W-1:0] rd_dat  // Held until the next read
);

   logic [`FIFO_DAT_W-1:0] ram [2**`FIFO_ADD_W];

   always_ff @(posedge clk) begin
      if (mem.cs) begin
         if (mem.wen) begin
            ram[mem.add] <= mem.dat;
         end else begin
            rd_dat <= ram[mem.add]; // Registered read port
         end
      end
   end

endmodule

// File: tb/tb_fifo_mc.sv
// Table-driven testbench for the multi-channel FIFO controller
// Rows of writes, requests and idle cycles are applied in a loop, a queue model per
// channel predicts status, errors and every output word, checked each cycle at negedge

`timescale 1ns/1ps

`include "fifo_mc_settings.svh"

module tb_fifo_mc
   import fifo_cfg_pkg::*;
   import fifo_io_pkg::*;
();

   localparam int N       = `FIFO_CH_N;
   localparam int SIZE    = 3;          // Words per channel region
   localparam int CRD     = `FIFO_CRD_N;
   localparam int SEED    = 35931;
   localparam int N_ROWS  = 58;
   localparam int TIMEOUT = N_ROWS * 2 + 64; // Cycles, reset included
   localparam int E_DAT   = 2;          // err word with dat_ovfl set
   localparam int E_REQ   = 1;          // err word with rqst_ovfl set

   localparam int T_RESET = 0;
   localparam int T_ORDER = 1;
   localparam int T_PRIO  = 2;
   localparam int T_WPRIO = 3;
   localparam int T_DOVF  = 4;
   localparam int T_ROVF  = 5;

   typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RQ} op_t;

   // One step, expected count and err word of that channel after the step
   typedef struct {
      op_t op;
      int  ch;
      int  cnt;
      int  err;
      int  test;
   } row_t;

   logic                        clk;
   logic                        rst_n;
   ch_cfg_t   [N-1:0]           cfg;
   usr_word_t                   usr_in;
   rd_req_t                     rd_in;
   usr_word_t                   usr_out;
   logic      [N-1:0]           fc_rqst_rdy_n;
   ch_sts_t   [N-1:0]           sts;
   ch_err_t   [N-1:0]           err;

   // Reference model
   logic [`FIFO_DAT_W-1:0] mq [N][$]; // Stored words per channel
   int                     mcrd [N];  // Credits per channel
   ch_err_t                exp_err [N];
   logic                   exp_vld;   // Output expected this cycle
   logic [`FIFO_CH_W-1:0]  exp_ch;
   logic [`FIFO_DAT_W-1:0] exp_dat;
   logic                   prev_wr;   // Write offered last cycle

   int n_checks;
   int n_errors;
   int err_mark;  // Error count when the last test ended
   int n_tests;

   string test_name [6] = '{"reset", "order_wrap", "priority", "write_prio",
                            "data_ovfl", "rqst_ovfl"};

   row_t rows [N_ROWS] = '{
      // Channel 1, three passes through its region
      '{OP_WR, 1, 1, 0, T_ORDER},   '{OP_WR, 1, 2, 0, T_ORDER},   '{OP_WR, 1, 3, 0, T_ORDER},
      '{OP_RQ, 1, 3, 0, T_ORDER},   '{OP_RQ, 1, 2, 0, T_ORDER},   '{OP_RQ, 1, 1, 0, T_ORDER},
      '{OP_IDLE, 1, 0, 0, T_ORDER}, '{OP_WR, 1, 1, 0, T_ORDER},   '{OP_WR, 1, 2, 0, T_ORDER},
      '{OP_WR, 1, 3, 0, T_ORDER},   '{OP_RQ, 1, 3, 0, T_ORDER},   '{OP_RQ, 1, 2, 0, T_ORDER},
      '{OP_RQ, 1, 1, 0, T_ORDER},   '{OP_IDLE, 1, 0, 0, T_ORDER}, '{OP_WR, 1, 1, 0, T_ORDER},
      '{OP_WR, 1, 2, 0, T_ORDER},   '{OP_RQ, 1, 2, 0, T_ORDER},   '{OP_RQ, 1, 1, 0, T_ORDER},
      '{OP_IDLE, 1, 0, 0, T_ORDER},
      // Credits first, then data, then idle so that all compete
      '{OP_RQ, 3, 0, 0, T_PRIO},    '{OP_RQ, 2, 0, 0, T_PRIO},    '{OP_RQ, 0, 0, 0, T_PRIO},
      '{OP_RQ, 0, 0, 0, T_PRIO},    '{OP_WR, 3, 1, 0, T_PRIO},    '{OP_WR, 2, 1, 0, T_PRIO},
      '{OP_WR, 0, 1, 0, T_PRIO},    '{OP_WR, 0, 2, 0, T_PRIO},    '{OP_IDLE, 0, 1, 0, T_PRIO},
      '{OP_IDLE, 0, 0, 0, T_PRIO},  '{OP_IDLE, 2, 0, 0, T_PRIO},  '{OP_IDLE, 3, 0, 0, T_PRIO},
      // Channel 2 ready to read while channel 0 keeps writing
      '{OP_RQ, 2, 0, 0, T_WPRIO},   '{OP_RQ, 2, 0, 0, T_WPRIO},   '{OP_WR, 2, 1, 0, T_WPRIO},
      '{OP_WR, 0, 1, 0, T_WPRIO},   '{OP_WR, 0, 2, 0, T_WPRIO},   '{OP_IDLE, 2, 0, 0, T_WPRIO},
      '{OP_IDLE, 0, 2, 0, T_WPRIO}, '{OP_RQ, 0, 2, 0, T_WPRIO},   '{OP_RQ, 0, 1, 0, T_WPRIO},
      '{OP_IDLE, 0, 0, 0, T_WPRIO},
      // Fourth write is dropped
      '{OP_WR, 1, 1, 0, T_DOVF},    '{OP_WR, 1, 2, 0, T_DOVF},    '{OP_WR, 1, 3, 0, T_DOVF},
      '{OP_WR, 1, 3, E_DAT, T_DOVF}, '{OP_IDLE, 1, 3, 0, T_DOVF}, '{OP_RQ, 1, 3, 0, T_DOVF},
      '{OP_RQ, 1, 2, 0, T_DOVF},    '{OP_RQ, 1, 1, 0, T_DOVF},    '{OP_IDLE, 1, 0, 0, T_DOVF},
      // Fifth request is dropped
      '{OP_RQ, 3, 0, 0, T_ROVF},    '{OP_RQ, 3, 0, 0, T_ROVF},    '{OP_RQ, 3, 0, 0, T_ROVF},
      '{OP_RQ, 3, 0, 0, T_ROVF},    '{OP_RQ, 3, 0, E_REQ, T_ROVF}, '{OP_WR, 3, 1, 0, T_ROVF},
      '{OP_IDLE, 3, 0, 0, T_ROVF},  '{OP_IDLE, 3, 0, 0, T_ROVF}
   };

   fifo_mc_top dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg           (cfg),
      .usr_in        (usr_in),
      .rd_in         (rd_in),
      .usr_out       (usr_out),
      .fc_rqst_rdy_n (fc_rqst_rdy_n),
      .sts           (sts),
      .err           (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk; // 100 ns period
   end

   task automatic check_val(input string name, input int got, input int want);
      n_checks++;
      if (got != want) begin
         n_errors++;
         $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, want);
      end
   endtask

   // Called right after a rising edge
   task automatic drive_row(input row_t r);
      logic [31:0] rnd;
      rnd = $urandom();
      usr_in.vld <= (r.op == OP_WR);
      usr_in.ch  <= r.ch[`FIFO_CH_W-1:0];
      usr_in.dat <= rnd[`FIFO_DAT_W-1:0]; // Fresh payload every cycle
      rd_in.vld  <= (r.op == OP_RQ);
      rd_in.ch   <= r.ch[`FIFO_CH_W-1:0];
   endtask

   // Compare every DUT output with the model, mid-cycle
   task automatic check_cycle();
      for (int c = 0; c < N; c++) begin
         check_val($sformatf("sts[%0d].count", c), int'(sts[c].count), mq[c].size());
         check_val($sformatf("sts[%0d].full", c), int'(sts[c].full), int'(mq[c].size() == SIZE));
         check_val($sformatf("sts[%0d].empty", c), int'(sts[c].empty), int'(mq[c].size() == 0));
         check_val($sformatf("sts[%0d].crd_count", c), int'(sts[c].crd_count), mcrd[c]);
         check_val($sformatf("sts[%0d].crd_full", c), int'(sts[c].crd_full), int'(mcrd[c] == CRD));
         check_val($sformatf("sts[%0d].crd_empty", c), int'(sts[c].crd_empty), int'(mcrd[c] == 0));
         check_val($sformatf("fc_rqst_rdy_n[%0d]", c), int'(fc_rqst_rdy_n[c]),
                   int'(mcrd[c] == CRD));
         check_val($sformatf("err[%0d]", c), int'(err[c]), int'(exp_err[c]));
      end
      check_val("usr_out.vld", int'(usr_out.vld), int'(exp_vld));
      if (exp_vld) begin
         check_val("usr_out.ch", int'(usr_out.ch), int'(exp_ch));
         check_val("usr_out.dat", int'(usr_out.dat), int'(exp_dat));
      end
      n_checks++;
      if (prev_wr && usr_out.vld) begin
         n_errors++;
         $display("Read data left the DUT right after a write cycle at %0t", $time);
      end
   endtask

   // Advance the model by the cycle whose inputs are on the DUT now
   task automatic model_step();
      int   gnt;
      logic rq_ok;
      gnt   = -1;
      rq_ok = rd_in.vld && (mcrd[rd_in.ch] < CRD); // Credit bank before any pop
      exp_vld = 1'b0;
      for (int c = 0; c < N; c++) exp_err[c] = '0;
      if (!usr_in.vld) begin
         for (int c = N - 1; c >= 0; c--) begin
            if (mcrd[c] > 0 && mq[c].size() > 0) gnt = c; // Lowest index wins
         end
      end
      if (gnt >= 0) begin
         exp_vld = 1'b1;
         exp_ch  = gnt[`FIFO_CH_W-1:0];
         exp_dat = mq[gnt].pop_front();
         mcrd[gnt]--;
      end
      if (usr_in.vld) begin
         if (mq[usr_in.ch].size() == SIZE) exp_err[usr_in.ch].dat_ovfl = 1'b1;
         else mq[usr_in.ch].push_back(usr_in.dat);
      end
      if (rd_in.vld) begin
         if (rq_ok) mcrd[rd_in.ch]++;
         else exp_err[rd_in.ch].rqst_ovfl = 1'b1;
      end
      prev_wr = usr_in.vld;
   endtask

   task automatic check_row(input row_t r);
      check_val($sformatf("sts[%0d].count", r.ch), int'(sts[r.ch].count), r.cnt);
      check_val($sformatf("err[%0d]", r.ch), int'(err[r.ch]), r.err);
   endtask

   task automatic finish_test(input int t);
      n_tests++;
      $display("test %s done, %0d errors", test_name[t], n_errors - err_mark);
      err_mark = n_errors;
   endtask

   initial begin
      void'($urandom(SEED));
      n_checks = 0;
      n_errors = 0;
      err_mark = 0;
      n_tests  = 0;
      rst_n  = 1'b0;
      usr_in = '0;
      rd_in  = '0;
      for (int c = 0; c < N; c++) begin
         cfg[c].base = c * 4; // Regions 4 apart, last word unused
         cfg[c].size = SIZE;
         mcrd[c]     = 0;
         exp_err[c]  = '0;
      end
      exp_vld = 1'b0;
      exp_ch  = '0;
      exp_dat = '0;
      prev_wr = 1'b0;

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_cycle(); // Reset state
      model_step();
      finish_test(T_RESET);

      for (int i = 0; i <= N_ROWS; i++) begin
         @(posedge clk);
         if (i < N_ROWS) drive_row(rows[i]);
         else drive_row('{OP_IDLE, 0, 0, 0, T_ROVF}); // Flush cycle
         @(negedge clk);
         check_cycle();
         if (i > 0) check_row(rows[i-1]); // Row i-1 took effect at the last edge
         model_step();
         if (i == N_ROWS) finish_test(rows[i-1].test);
         else if (i > 0 && rows[i].test != rows[i-1].test) finish_test(rows[i-1].test);
      end

      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run stopped after %0d cycles before the table was done", cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule
